//--- verilog/mc_defines.svh
`ifndef MC_DEFINES_SVH
`define MC_DEFINES_SVH

// Tile row
`define MC_NUM_TILES 4
`define MC_TILE_WORDS 64

// Host port widths
`define MC_AXIL_ADDR_W 16
`define MC_AXIL_DATA_W 32
`define MC_AXIL_MASK_W (`MC_AXIL_DATA_W / 8)

`endif

//--- verilog/mc_pkg.sv
`include "mc_defines.svh"

package mc_pkg;

  typedef logic [`MC_AXIL_DATA_W-1:0] mc_data_t;
  typedef logic [`MC_AXIL_MASK_W-1:0] mc_mask_t;
  typedef logic [`MC_AXIL_ADDR_W-1:0] mc_axil_addr_t;
  typedef logic [$clog2(`MC_TILE_WORDS)-1:0] mc_word_addr_t;
  typedef logic [$clog2(`MC_NUM_TILES)-1:0] mc_tile_id_t;
  typedef logic [1:0] mc_resp_t;

  localparam mc_resp_t mc_resp_okay = 2'b00;

  typedef enum logic [1:0] {
    MC_OP_LOAD,
    MC_OP_STORE,
    MC_OP_STORE_MASKED
  } mc_op_e;

  typedef enum logic {
    MC_RET_CREDIT,
    MC_RET_DATA
  } mc_ret_e;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_RET,
    RESPOND
  } mc_client_state_e;

  // Host transaction as seen by the dispatcher
  typedef struct packed {
    logic          write;
    mc_axil_addr_t addr;
    mc_data_t      data;
    mc_mask_t      mask;
  } mc_req_s;

  typedef struct packed {
    mc_op_e        op;
    mc_tile_id_t   dest;
    mc_word_addr_t addr;
    mc_mask_t      mask;
    mc_data_t      data;
  } mc_packet_s;

  typedef struct packed {
    mc_ret_e  ret_type;
    mc_data_t data;
  } mc_ret_packet_s;

endpackage

//--- verilog/mc_axil_client.sv
`timescale 1ns/1ps

module mc_axil_client
  import mc_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_n_i,

  input  mc_axil_addr_t  s_axil_awaddr_i,
  input  logic           s_axil_awvalid_i,
  output logic           s_axil_awready_o,

  input  mc_data_t       s_axil_wdata_i,
  input  mc_mask_t       s_axil_wstrb_i,
  input  logic           s_axil_wvalid_i,
  output logic           s_axil_wready_o,

  output mc_resp_t       s_axil_bresp_o,
  output logic           s_axil_bvalid_o,
  input  logic           s_axil_bready_i,

  input  mc_axil_addr_t  s_axil_araddr_i,
  input  logic           s_axil_arvalid_i,
  output logic           s_axil_arready_o,

  output mc_data_t       s_axil_rdata_o,
  output mc_resp_t       s_axil_rresp_o,
  output logic           s_axil_rvalid_o,
  input  logic           s_axil_rready_i,

  output logic           req_v_o,
  output mc_req_s        req_o,
  input  logic           req_ready_and_i,

  input  logic           ret_v_i,
  input  mc_ret_packet_s ret_i,
  output logic           ret_ready_and_o
);

  mc_client_state_e state_r, state_n;
  mc_req_s          req_r;
  mc_data_t         rdata_r;
  logic             aw_held_r, w_held_r;
  logic             aw_hs, w_hs, ar_hs;
  logic             write_go;
  logic             resp_done;

  assign s_axil_awready_o = (state_r == IDLE) & ~aw_held_r;
  assign s_axil_wready_o  = (state_r == IDLE) & ~w_held_r;
  // Any write activity blocks the read channel
  assign s_axil_arready_o = (state_r == IDLE) & ~aw_held_r & ~w_held_r
                            & ~s_axil_awvalid_i & ~s_axil_wvalid_i;

  assign aw_hs = s_axil_awvalid_i & s_axil_awready_o;
  assign w_hs  = s_axil_wvalid_i & s_axil_wready_o;
  assign ar_hs = s_axil_arvalid_i & s_axil_arready_o;

  // Both halves of the write present, held or arriving now
  assign write_go  = (aw_held_r | aw_hs) & (w_held_r | w_hs);
  assign resp_done = req_r.write ? s_axil_bready_i : s_axil_rready_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      IDLE: begin
        if (write_go || ar_hs) begin
          state_n = ISSUE;
        end
      end
      ISSUE: begin
        if (req_ready_and_i) begin
          state_n = WAIT_RET;
        end
      end
      WAIT_RET: begin
        if (ret_v_i) begin
          state_n = RESPOND;
        end
      end
      RESPOND: begin
        if (resp_done) begin
          state_n = IDLE;
        end
      end
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r   <= IDLE;
      aw_held_r <= 1'b0;
      w_held_r  <= 1'b0;
    end else begin
      state_r <= state_n;
      if (write_go) begin
        aw_held_r <= 1'b0;
        w_held_r  <= 1'b0;
      end else begin
        if (aw_hs) begin
          aw_held_r <= 1'b1;
        end
        if (w_hs) begin
          w_held_r <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      req_r.addr <= s_axil_awaddr_i;
    end
    if (w_hs) begin
      req_r.data <= s_axil_wdata_i;
      req_r.mask <= s_axil_wstrb_i;
    end
    if (write_go) begin
      req_r.write <= 1'b1;
    end
    if (ar_hs) begin
      req_r.write <= 1'b0;
      req_r.addr  <= s_axil_araddr_i;
    end
    if (ret_v_i && ret_ready_and_o) begin
      rdata_r <= (ret_i.ret_type == MC_RET_DATA) ? ret_i.data : '0;
    end
  end

  assign req_v_o         = (state_r == ISSUE);
  assign req_o           = req_r;
  assign ret_ready_and_o = (state_r == WAIT_RET);

  assign s_axil_bvalid_o = (state_r == RESPOND) & req_r.write;
  assign s_axil_rvalid_o = (state_r == RESPOND) & ~req_r.write;
  assign s_axil_bresp_o  = mc_resp_okay;
  assign s_axil_rresp_o  = mc_resp_okay;
  assign s_axil_rdata_o  = rdata_r;

endmodule

//--- verilog/mc_req_dispatch.sv
`timescale 1ns/1ps

`include "mc_defines.svh"

module mc_req_dispatch
  import mc_pkg::*;
(
  input  logic                     req_v_i,
  input  mc_req_s                  req_i,
  output logic                     req_ready_and_o,

  output logic [`MC_NUM_TILES-1:0] pkt_v_o,
  output mc_packet_s               pkt_o,
  input  logic [`MC_NUM_TILES-1:0] pkt_ready_i
);

  // Byte address layout: word offset, word index, tile number
  localparam int word_lsb_lp = $clog2(`MC_AXIL_MASK_W);
  localparam int tile_lsb_lp = word_lsb_lp + $bits(mc_word_addr_t);

  mc_tile_id_t dest;
  logic        full_mask;

  assign dest      = req_i.addr[tile_lsb_lp +: $bits(mc_tile_id_t)];
  assign full_mask = (req_i.mask == '1);

  always_comb begin
    pkt_o.dest = dest;
    pkt_o.addr = req_i.addr[word_lsb_lp +: $bits(mc_word_addr_t)];
    pkt_o.data = req_i.data;
    if (!req_i.write) begin
      pkt_o.op   = MC_OP_LOAD;
      pkt_o.mask = '1;
    end else if (full_mask) begin
      pkt_o.op   = MC_OP_STORE;
      pkt_o.mask = req_i.mask;
    end else begin
      pkt_o.op   = MC_OP_STORE_MASKED;
      pkt_o.mask = req_i.mask;
    end
  end

  // Valid goes to the addressed tile only
  always_comb begin
    pkt_v_o       = '0;
    pkt_v_o[dest] = req_v_i;
  end

  assign req_ready_and_o = pkt_ready_i[dest];

endmodule

//--- verilog/mc_tile_mem.sv
`timescale 1ns/1ps

`include "mc_defines.svh"

module mc_tile_mem
  import mc_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_n_i,

  input  logic           pkt_v_i,
  input  mc_packet_s     pkt_i,
  output logic           pkt_ready_o,

  output logic           ret_v_o,
  output mc_ret_packet_s ret_o,
  input  logic           ret_yumi_i
);

  mc_data_t       mem [`MC_TILE_WORDS];
  logic           ret_v_r;
  mc_ret_packet_s ret_r;
  logic           accept;
  logic           is_load;

  // Return slot frees up this cycle or is already empty
  assign pkt_ready_o = ~ret_v_r | ret_yumi_i;
  assign accept      = pkt_v_i & pkt_ready_o;
  assign is_load     = (pkt_i.op == MC_OP_LOAD);

  always_ff @(posedge clk_i) begin
    if (accept && !is_load) begin
      for (int b = 0; b < `MC_AXIL_MASK_W; b++) begin
        if (pkt_i.mask[b]) begin
          mem[pkt_i.addr][8*b +: 8] <= pkt_i.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (is_load) begin
        ret_r.ret_type <= MC_RET_DATA;
        ret_r.data     <= mem[pkt_i.addr];
      end else begin
        ret_r.ret_type <= MC_RET_CREDIT;
        ret_r.data     <= '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ret_v_r <= 1'b0;
    end else if (accept) begin
      ret_v_r <= 1'b1;
    end else if (ret_yumi_i) begin
      ret_v_r <= 1'b0;
    end
  end

  assign ret_v_o = ret_v_r;
  assign ret_o   = ret_r;

endmodule

//--- verilog/mc_return_collect.sv
`timescale 1ns/1ps

`include "mc_defines.svh"

module mc_return_collect
  import mc_pkg::*;
(
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,

  input  logic           [`MC_NUM_TILES-1:0]       ret_v_i,
  input  mc_ret_packet_s [`MC_NUM_TILES-1:0]       ret_i,
  output logic           [`MC_NUM_TILES-1:0]       ret_yumi_o,

  output logic                                     ret_v_o,
  output mc_ret_packet_s                           ret_o,
  input  logic                                     ret_ready_and_i
);

  mc_tile_id_t ptr_r;
  mc_tile_id_t sel;
  logic        xfer;

  // Walk backwards so the valid tile nearest the pointer wins
  always_comb begin
    sel = ptr_r;
    for (int i = `MC_NUM_TILES - 1; i >= 0; i--) begin
      if (ret_v_i[(int'(ptr_r) + i) % `MC_NUM_TILES]) begin
        sel = mc_tile_id_t'((int'(ptr_r) + i) % `MC_NUM_TILES);
      end
    end
  end

  assign ret_v_o = |ret_v_i;
  assign ret_o   = ret_i[sel];
  assign xfer    = ret_v_o & ret_ready_and_i;

  always_comb begin
    ret_yumi_o      = '0;
    ret_yumi_o[sel] = xfer;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_r <= '0;
    end else if (xfer) begin
      ptr_r <= mc_tile_id_t'((int'(sel) + 1) % `MC_NUM_TILES);
    end
  end

endmodule

//--- verilog/mc_axil_subsys_top.sv
`timescale 1ns/1ps

`include "mc_defines.svh"

module mc_axil_subsys_top
  import mc_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,

  input  mc_axil_addr_t s_axil_awaddr_i,
  input  logic          s_axil_awvalid_i,
  output logic          s_axil_awready_o,

  input  mc_data_t      s_axil_wdata_i,
  input  mc_mask_t      s_axil_wstrb_i,
  input  logic          s_axil_wvalid_i,
  output logic          s_axil_wready_o,

  output mc_resp_t      s_axil_bresp_o,
  output logic          s_axil_bvalid_o,
  input  logic          s_axil_bready_i,

  input  mc_axil_addr_t s_axil_araddr_i,
  input  logic          s_axil_arvalid_i,
  output logic          s_axil_arready_o,

  output mc_data_t      s_axil_rdata_o,
  output mc_resp_t      s_axil_rresp_o,
  output logic          s_axil_rvalid_o,
  input  logic          s_axil_rready_i
);

  logic                                   req_v;
  mc_req_s                                req;
  logic                                   req_ready_and;

  logic           [`MC_NUM_TILES-1:0]     pkt_v;
  mc_packet_s                             pkt;
  logic           [`MC_NUM_TILES-1:0]     pkt_ready;

  logic           [`MC_NUM_TILES-1:0]     tile_ret_v;
  mc_ret_packet_s [`MC_NUM_TILES-1:0]     tile_ret;
  logic           [`MC_NUM_TILES-1:0]     tile_ret_yumi;

  logic                                   ret_v;
  mc_ret_packet_s                         ret;
  logic                                   ret_ready_and;

  mc_axil_client i_client (
    .req_v_o         (req_v),
    .req_o           (req),
    .req_ready_and_i (req_ready_and),
    .ret_v_i         (ret_v),
    .ret_i           (ret),
    .ret_ready_and_o (ret_ready_and),
    .*
  );

  mc_req_dispatch i_dispatch (
    .req_v_i         (req_v),
    .req_i           (req),
    .req_ready_and_o (req_ready_and),
    .pkt_v_o         (pkt_v),
    .pkt_o           (pkt),
    .pkt_ready_i     (pkt_ready)
  );

  for (genvar t = 0; t < `MC_NUM_TILES; t++) begin : g_tile
    mc_tile_mem i_tile (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .pkt_v_i     (pkt_v[t]),
      .pkt_i       (pkt),
      .pkt_ready_o (pkt_ready[t]),
      .ret_v_o     (tile_ret_v[t]),
      .ret_o       (tile_ret[t]),
      .ret_yumi_i  (tile_ret_yumi[t])
    );
  end

  mc_return_collect i_collect (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .ret_v_i         (tile_ret_v),
    .ret_i           (tile_ret),
    .ret_yumi_o      (tile_ret_yumi),
    .ret_v_o         (ret_v),
    .ret_o           (ret),
    .ret_ready_and_i (ret_ready_and)
  );

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real period_p       = 40.0,
  parameter int  reset_cycles_p = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2.0) clk_o = ~clk_o;
  end

  // Release away from the active edge
  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles_p) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- tests/mc_axil_checker.sv
`timescale 1ns/1ps

`include "mc_defines.svh"

module mc_axil_checker
  import mc_pkg::*;
(
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     bvalid_i,
  input logic                     bready_i,
  input mc_resp_t                 bresp_i,
  input logic                     rvalid_i,
  input logic                     rready_i,
  input mc_data_t                 rdata_i,
  input logic                     req_v_i,
  input logic [`MC_NUM_TILES-1:0] pkt_v_i,
  input logic [`MC_NUM_TILES-1:0] tile_ret_v_i,
  input logic                     ret_v_i
);

  int unsigned fail_count = 0;

  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      fail_count++;
      $error("bvalid dropped or bresp changed before bready");
    end

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else begin
      fail_count++;
      $error("rvalid dropped or rdata changed before rready");
    end

  a_b_r_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(bvalid_i && rvalid_i))
    else begin
      fail_count++;
      $error("bvalid and rvalid high together");
    end

  // Nothing may be valid while reset is held
  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !(bvalid_i || rvalid_i || req_v_i || ret_v_i
                   || (|pkt_v_i) || (|tile_ret_v_i)))
    else begin
      fail_count++;
      $error("valid signal high during reset");
    end

endmodule

//--- tests/tb_mc_axil.sv
`timescale 1ns/1ps

`include "mc_defines.svh"

module tb_mc_axil
  import mc_pkg::*;
();

  localparam int timeout_lp   = 100;
  localparam int num_words_lp = `MC_NUM_TILES * `MC_TILE_WORDS;

  logic          clk, rst_n;
  mc_axil_addr_t awaddr, araddr;
  logic          awvalid, awready, wvalid, wready, arvalid, arready;
  mc_data_t      wdata, rdata;
  mc_mask_t      wstrb;
  mc_resp_t      bresp, rresp;
  logic          bvalid, bready, rvalid, rready;
  mc_data_t      ref_mem [num_words_lp];
  int            seed = 70618;

  tb_clk_gen #(.period_p(40.0), .reset_cycles_p(16)) i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mc_axil_subsys_top i_dut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  bind mc_axil_subsys_top mc_axil_checker i_checker (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .bvalid_i     (s_axil_bvalid_o),
    .bready_i     (s_axil_bready_i),
    .bresp_i      (s_axil_bresp_o),
    .rvalid_i     (s_axil_rvalid_o),
    .rready_i     (s_axil_rready_i),
    .rdata_i      (s_axil_rdata_o),
    .req_v_i      (req_v),
    .pkt_v_i      (pkt_v),
    .tile_ret_v_i (tile_ret_v),
    .ret_v_i      (ret_v)
  );

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  always @(negedge clk) begin
    if (i_dut.i_checker.fail_count != 0) begin
      fail_now("Assertion in the bound AXI checker failed");
    end
  end

  task automatic compare_data(input string name, input mc_data_t exp, input mc_data_t act);
    if (act !== exp) begin
      fail_now($sformatf("Error at %0d ns: %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic compare_resp(input string name, input mc_resp_t exp, input mc_resp_t act);
    if (act !== exp) begin
      fail_now($sformatf("Error at %0d ns: %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  // Tile number in [9:8] and word index in [7:2] form one flat index
  function automatic int word_index(input mc_axil_addr_t addr);
    return int'(addr[9:2]);
  endfunction

  function automatic mc_data_t fill_word(input mc_axil_addr_t addr);
    return {addr ^ 16'hA5C3, ~addr};
  endfunction

  task automatic model_write(input mc_axil_addr_t addr, input mc_data_t data,
                             input mc_mask_t strb);
    int idx;
    idx = word_index(addr);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        ref_mem[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  // order 0 drives AW and W together, 1 leads with AW, 2 leads with W
  task automatic axil_write(input mc_axil_addr_t addr, input mc_data_t data,
                            input mc_mask_t strb, input int order, input int hold);
    bit aw_done;
    bit w_done;
    int cnt;
    aw_done = 1'b0;
    w_done  = 1'b0;
    cnt     = 0;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = (order != 2);
    wvalid  = (order != 1);
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      aw_done = aw_done | (awvalid & awready);
      w_done  = w_done | (wvalid & wready);
      @(negedge clk);
      awvalid = !aw_done;
      wvalid  = !w_done;
      cnt++;
      if (cnt > timeout_lp) fail_now("Timeout waiting for AW and W handshakes");
    end
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > timeout_lp) fail_now("Timeout waiting for bvalid");
    end while (!bvalid);
    compare_resp("s_axil_bresp_o", mc_resp_okay, bresp);
    repeat (hold) begin
      @(posedge clk);
      if (!bvalid) fail_now("bvalid dropped while bready was low");
      compare_resp("s_axil_bresp_o", mc_resp_okay, bresp);
    end
    @(negedge clk);
    bready = 1'b1;
    @(posedge clk);
    @(negedge clk);
    bready = 1'b0;
    model_write(addr, data, strb);
  endtask

  task automatic axil_read(input mc_axil_addr_t addr, input int hold);
    mc_data_t exp;
    int       cnt;
    exp = ref_mem[word_index(addr)];
    cnt = 0;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > timeout_lp) fail_now("Timeout waiting for arready");
    end while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > timeout_lp) fail_now("Timeout waiting for rvalid");
    end while (!rvalid);
    compare_data("s_axil_rdata_o", exp, rdata);
    compare_resp("s_axil_rresp_o", mc_resp_okay, rresp);
    repeat (hold) begin
      @(posedge clk);
      if (!rvalid) fail_now("rvalid dropped while rready was low");
      compare_data("s_axil_rdata_o", exp, rdata);
    end
    @(negedge clk);
    rready = 1'b1;
    @(posedge clk);
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic full_word_test();
    axil_write(16'h0124, 32'hDEADBEEF, 4'hF, 0, 0);
    axil_read(16'h0124, 0);
  endtask

  task automatic partial_write_test();
    axil_write(16'h0208, 32'h11223344, 4'hF, 0, 0);
    axil_write(16'h0208, 32'h000000AA, 4'b0001, 0, 0);
    axil_read(16'h0208, 0);
    axil_write(16'h0208, 32'h00BB0000, 4'b0100, 1, 0);
    axil_read(16'h0208, 0);
    axil_write(16'h0208, 32'hCCDD0000, 4'b1100, 2, 0);
    axil_read(16'h0208, 0);
    axil_write(16'h0208, 32'h0000EEFF, 4'b0011, 0, 0);
    axil_read(16'h0208, 0);
  endtask

  task automatic tile_select_test();
    for (int t = 0; t < `MC_NUM_TILES; t++) begin
      axil_write(mc_axil_addr_t'((t << 8) | (5 << 2)), 32'hC0DE0000 | t, 4'hF, 0, 0);
    end
    for (int t = 0; t < `MC_NUM_TILES; t++) begin
      axil_read(mc_axil_addr_t'((t << 8) | (5 << 2)), 0);
    end
  endtask

  // Bits above 9 are ignored by the bridge
  task automatic alias_test();
    axil_write(16'h0310, 32'h5555AAAA, 4'hF, 0, 0);
    axil_read(16'hF710, 0);
    axil_write(16'hAB10, 32'h0F0F1234, 4'b0110, 0, 0);
    axil_read(16'h0310, 0);
  endtask

  task automatic backpressure_test();
    axil_write(16'h0040, 32'h8BADF00D, 4'hF, 0, 5);
    axil_read(16'h0040, 4);
    axil_write(16'h0144, 32'h600DCAFE, 4'hF, 0, 0);
    axil_read(16'h0144, 0);
  endtask

  task automatic random_test(input int count);
    mc_axil_addr_t addr;
    for (int n = 0; n < count; n++) begin
      addr = mc_axil_addr_t'($random(seed)) & 16'hFFFC;
      if ($random(seed) & 1) begin
        axil_write(addr, mc_data_t'($random(seed)), mc_mask_t'($random(seed)),
                   int'($unsigned($random(seed)) % 3), int'($unsigned($random(seed)) % 3));
      end else begin
        axil_read(addr, int'($unsigned($random(seed)) % 3));
      end
    end
  endtask

  initial begin
    int cnt;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    cnt     = 0;
    while (!rst_n) begin
      @(negedge clk);
      cnt++;
      if (cnt > timeout_lp) fail_now("Timeout waiting for reset release");
    end
    // Tile memories power up unknown
    for (int i = 0; i < num_words_lp; i++) begin
      axil_write(mc_axil_addr_t'(i << 2), fill_word(mc_axil_addr_t'(i << 2)), 4'hF, 0, 0);
    end
    full_word_test();
    partial_write_test();
    tile_select_test();
    alias_test();
    backpressure_test();
    random_test(300);
    if (i_dut.i_checker.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+verilog
verilog/mc_pkg.sv
verilog/mc_axil_client.sv
verilog/mc_req_dispatch.sv
verilog/mc_tile_mem.sv
verilog/mc_return_collect.sv
verilog/mc_axil_subsys_top.sv
tests/tb_clk_gen.sv
tests/mc_axil_checker.sv
tests/tb_mc_axil.sv
